// File: list.f
src/dm_reg_pkg.sv
src/sb_bus_pkg.sv
src/sb_lane_align.sv
src/sb_master.sv
src/dmi_regfile.sv
src/dm_top.sv
testbench/dm_top_checker.sv
testbench/dm_top_tb.sv

// File: src/dm_reg_pkg.sv
// debug register package
// DMI access format, debug register addresses and sbcs field layout

package dm_reg_pkg;

   localparam int DMI_ADDR_W = 7;
   localparam int DM_WORD_W  = 32;

   typedef logic [DMI_ADDR_W-1:0] dmi_addr_t;
   typedef logic [DM_WORD_W-1:0]  dm_word_t;

   // one debugger access, valid for a single cycle
   typedef struct packed {
      logic      en;
      logic      wr;                                   // 1 write, 0 read
      dmi_addr_t addr;
      dm_word_t  wdata;
   } dmi_req_t;

   // **************************************************
   // register map
   // **************************************************
   localparam dmi_addr_t DMCONTROL_ADDR  = 7'h10;
   localparam dmi_addr_t SBCS_ADDR       = 7'h38;
   localparam dmi_addr_t SBADDRESS0_ADDR = 7'h39;
   localparam dmi_addr_t SBDATA0_ADDR    = 7'h3c;

   // dmcontrol bits
   localparam int DMCONTROL_DMACTIVE = 0;
   localparam int DMCONTROL_NDMRESET = 1;

   // sbcs field positions
   localparam int SBCS_VERSION_LSB     = 29;
   localparam int SBCS_SBBUSYERROR     = 22;
   localparam int SBCS_SBBUSY          = 21;
   localparam int SBCS_SBREADONADDR    = 20;
   localparam int SBCS_SBACCESS_LSB    = 17;
   localparam int SBCS_SBAUTOINCREMENT = 16;
   localparam int SBCS_SBREADONDATA    = 15;
   localparam int SBCS_SBERROR_LSB     = 12;
   localparam int SBCS_ASIZE_LSB       = 5;
   localparam int SBCS_ACCESS_OK_LSB   = 0;

   typedef logic [2:0] sbcs_version_t;
   typedef logic [6:0] sbcs_asize_t;
   typedef logic [4:0] sbcs_access_ok_t;
   typedef logic [2:0] sberror_t;

   // read-only sbcs constants
   localparam sbcs_version_t   SBCS_VERSION   = 3'd1;
   localparam sbcs_asize_t     SBCS_ASIZE     = 7'd32;      // 32-bit system address
   localparam sbcs_access_ok_t SBCS_ACCESS_OK = 5'b00111;   // 8, 16 and 32 bit accesses

endpackage

// File: src/dm_top.sv
// debug module top level
// debug register file plus a Wishbone system bus master,
// debug logic held in reset until dmactive is written

module dm_top
   import dm_reg_pkg::*;
   import sb_bus_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  dmi_req_t dmi_req,
   output dm_word_t dmi_rdata,
   output wb_req_t  wb_req,
   input  wb_rsp_t  wb_rsp,
   output logic     ndm_reset
);

   logic       dmactive;
   logic       dm_rst_n;                               // debug logic reset
   logic       start_rd, start_wr;
   sb_access_e sb_access;
   sb_addr_t   sb_addr;
   sb_data_t   sb_wdata;
   sb_status_t sb_status;

   assign dm_rst_n = rst_n & dmactive;

   dmi_regfile regfile_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .dm_rst_n  (dm_rst_n),
      .dmi_req   (dmi_req),
      .dmi_rdata (dmi_rdata),
      .dmactive  (dmactive),
      .ndm_reset (ndm_reset),
      .sb_status (sb_status),
      .start_rd  (start_rd),
      .start_wr  (start_wr),
      .sb_access (sb_access),
      .sb_addr   (sb_addr),
      .sb_wdata  (sb_wdata)
   );

   sb_master master_i (
      .clk       (clk),
      .dm_rst_n  (dm_rst_n),
      .start_rd  (start_rd),
      .start_wr  (start_wr),
      .sb_access (sb_access),
      .sb_addr   (sb_addr),
      .sb_wdata  (sb_wdata),
      .sb_status (sb_status),
      .wb_req    (wb_req),
      .wb_rsp    (wb_rsp)
   );

endmodule

// File: src/dmi_regfile.sv
// debug register file
// decodes DMI accesses, holds dmcontrol, sbcs, sbaddress0 and sbdata0,
// raises system bus start pulses and returns registered read data

module dmi_regfile
   import dm_reg_pkg::*;
   import sb_bus_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       dm_rst_n,
   input  dmi_req_t   dmi_req,
   output dm_word_t   dmi_rdata,
   output logic       dmactive,
   output logic       ndm_reset,
   input  sb_status_t sb_status,
   output logic       start_rd,
   output logic       start_wr,
   output sb_access_e sb_access,
   output sb_addr_t   sb_addr,
   output sb_data_t   sb_wdata
);

   logic       busy;
   logic       dmi_wr, dmi_rd;
   logic       dmctl_wr, sbcs_wr, addr_wr, data_wr, data_rd;
   logic       sb_touch;                               // access to sbaddress0 or sbdata0
   logic       sbbusyerror, sbreadonaddr, sbautoincrement, sbreadondata;
   sb_access_e sbaccess;
   sberror_t   sberror;
   sb_addr_t   sbaddress0;
   sb_addr_t   addr_incr;
   sb_data_t   sbdata0;
   dm_word_t   sbcs_value;
   dm_word_t   rdata_mux;

   assign busy = sb_status.busy;

   // **************************************************
   // DMI decode
   // **************************************************
   assign dmi_wr   = dmi_req.en & dmi_req.wr;
   assign dmi_rd   = dmi_req.en & ~dmi_req.wr;
   assign dmctl_wr = dmi_wr & (dmi_req.addr == DMCONTROL_ADDR);
   assign sbcs_wr  = dmi_wr & (dmi_req.addr == SBCS_ADDR);
   assign addr_wr  = dmi_wr & (dmi_req.addr == SBADDRESS0_ADDR);
   assign data_wr  = dmi_wr & (dmi_req.addr == SBDATA0_ADDR);
   assign data_rd  = dmi_rd & (dmi_req.addr == SBDATA0_ADDR);
   assign sb_touch = dmi_req.en & ((dmi_req.addr == SBADDRESS0_ADDR) |
                                   (dmi_req.addr == SBDATA0_ADDR));

   // bus starts, only from an idle master
   assign start_wr = data_wr & ~busy;
   assign start_rd = ((addr_wr & sbreadonaddr) | (data_rd & sbreadondata)) & ~busy;

   assign addr_incr = sb_addr_t'(1) << sbaccess;      // access size in bytes

   // dmactive survives the debug reset it controls
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         dmactive <= 1'b0;
      end else if (dmctl_wr) begin
         dmactive <= dmi_req.wdata[DMCONTROL_DMACTIVE];
      end
   end

   always_ff @(posedge clk) begin
      if (!dm_rst_n) begin
         ndm_reset <= 1'b0;
      end else if (dmctl_wr) begin
         ndm_reset <= dmi_req.wdata[DMCONTROL_NDMRESET];
      end
   end

   // **************************************************
   // sbcs
   // **************************************************
   always_ff @(posedge clk) begin
      if (!dm_rst_n) begin
         sbreadonaddr    <= 1'b0;
         sbaccess        <= ACC8;
         sbautoincrement <= 1'b0;
         sbreadondata    <= 1'b0;
      end else if (sbcs_wr && !busy) begin
         sbreadonaddr    <= dmi_req.wdata[SBCS_SBREADONADDR];
         sbaccess        <= sb_access_e'(dmi_req.wdata[SBCS_SBACCESS_LSB +: $bits(sb_access_e)]);
         sbautoincrement <= dmi_req.wdata[SBCS_SBAUTOINCREMENT];
         sbreadondata    <= dmi_req.wdata[SBCS_SBREADONDATA];
      end
   end

   always_ff @(posedge clk) begin
      if (!dm_rst_n) begin
         sbbusyerror <= 1'b0;
      end else if (sb_touch && busy) begin
         sbbusyerror <= 1'b1;                          // collision with a pending access
      end else if (sbcs_wr && dmi_req.wdata[SBCS_SBBUSYERROR]) begin
         sbbusyerror <= 1'b0;                          // write 1 to clear
      end
   end

   always_ff @(posedge clk) begin
      if (!dm_rst_n) begin
         sberror <= '0;
      end else if (sb_status.err_valid) begin
         sberror <= sberror_t'(sb_status.err_code);
      end else if (sbcs_wr && !busy) begin
         sberror <= sberror & ~dmi_req.wdata[SBCS_SBERROR_LSB +: $bits(sberror_t)];
      end
   end

   // address and data, DMI side blocked while busy
   always_ff @(posedge clk) begin
      if (addr_wr && !busy) begin
         sbaddress0 <= dmi_req.wdata;
      end else if (sb_status.done && sbautoincrement) begin
         sbaddress0 <= sbaddress0 + addr_incr;
      end
   end

   always_ff @(posedge clk) begin
      if (data_wr && !busy) begin
         sbdata0 <= dmi_req.wdata;
      end else if (sb_status.rdata_valid) begin
         sbdata0 <= sb_status.rdata;                   // read result from the bus
      end
   end

   assign sb_access = sbaccess;
   assign sb_addr   = sbaddress0;
   assign sb_wdata  = sbdata0;

   // **************************************************
   // read path
   // **************************************************
   always_comb begin
      sbcs_value = '0;
      sbcs_value[SBCS_VERSION_LSB +: $bits(sbcs_version_t)]     = SBCS_VERSION;
      sbcs_value[SBCS_SBBUSYERROR]                              = sbbusyerror;
      sbcs_value[SBCS_SBBUSY]                                   = busy;
      sbcs_value[SBCS_SBREADONADDR]                             = sbreadonaddr;
      sbcs_value[SBCS_SBACCESS_LSB +: $bits(sb_access_e)]       = sbaccess;
      sbcs_value[SBCS_SBAUTOINCREMENT]                          = sbautoincrement;
      sbcs_value[SBCS_SBREADONDATA]                             = sbreadondata;
      sbcs_value[SBCS_SBERROR_LSB +: $bits(sberror_t)]          = sberror;
      sbcs_value[SBCS_ASIZE_LSB +: $bits(sbcs_asize_t)]         = SBCS_ASIZE;
      sbcs_value[SBCS_ACCESS_OK_LSB +: $bits(sbcs_access_ok_t)] = SBCS_ACCESS_OK;
   end

   always_comb begin
      case (dmi_req.addr)
         DMCONTROL_ADDR:  rdata_mux = {30'b0, ndm_reset, dmactive};
         SBCS_ADDR:       rdata_mux = sbcs_value;
         SBADDRESS0_ADDR: rdata_mux = sbaddress0;
         SBDATA0_ADDR:    rdata_mux = sbdata0;
         default:         rdata_mux = '0;
      endcase
   end

   // reads as zero while the debug logic is inactive
   always_ff @(posedge clk) begin
      if (!dm_rst_n) begin
         dmi_rdata <= '0;
      end else if (dmi_rd) begin
         dmi_rdata <= rdata_mux;
      end
   end

endmodule

// File: src/sb_bus_pkg.sv
// system bus package
// Wishbone request/response, access size and error encodings,
// master state and the status sent back to the register file

package sb_bus_pkg;

   localparam int SB_ADDR_W = 32;
   localparam int SB_DATA_W = 32;
   localparam int SB_SEL_W  = SB_DATA_W / 8;

   typedef logic [SB_ADDR_W-1:0] sb_addr_t;
   typedef logic [SB_DATA_W-1:0] sb_data_t;
   typedef logic [SB_SEL_W-1:0]  sb_sel_t;

   // sbaccess encoding, ACC64 and above are rejected
   typedef enum logic [2:0] {
      ACC8  = 3'd0,
      ACC16 = 3'd1,
      ACC32 = 3'd2,
      ACC64 = 3'd3
   } sb_access_e;

   // sberror encoding
   typedef enum logic [2:0] {
      NONE      = 3'd0,
      BUS_ERR   = 3'd2,
      UNALIGNED = 3'd3,
      BAD_SIZE  = 3'd4
   } sb_err_e;

   // **************************************************
   // Wishbone classic
   // **************************************************
   typedef struct packed {
      logic     cyc;
      logic     stb;
      logic     we;
      sb_addr_t adr;                                   // word address
      sb_sel_t  sel;
      sb_data_t dat;
   } wb_req_t;

   typedef struct packed {
      logic     ack;
      logic     err;
      sb_data_t dat;
   } wb_rsp_t;

   typedef enum logic [1:0] {
      IDLE  = 2'd0,
      CHECK = 2'd1,
      BUS   = 2'd2,
      DONE  = 2'd3
   } sb_state_e;

   // master to register file
   typedef struct packed {
      logic     busy;
      logic     done;                                  // one cycle at the end of an access
      logic     err_valid;
      sb_err_e  err_code;
      logic     rdata_valid;
      sb_data_t rdata;
   } sb_status_t;

endpackage

// File: src/sb_lane_align.sv
// system bus lane steering
// byte select and replicated write data from size and address,
// read lane shifted down and zero extended

module sb_lane_align
   import sb_bus_pkg::*;
(
   input  sb_access_e access,
   input  sb_addr_t   addr,
   input  sb_data_t   wdata,
   input  sb_data_t   bus_rdata,
   output sb_sel_t    sel,
   output sb_data_t   bus_wdata,
   output sb_data_t   rdata
);

   sb_data_t shifted;

   assign shifted = bus_rdata >> {addr[1:0], 3'b000};   // selected lane down to bit 0

   always_comb begin
      case (access)
         ACC8: begin
            sel       = sb_sel_t'(4'b0001) << addr[1:0];
            bus_wdata = {4{wdata[7:0]}};
            rdata     = {24'b0, shifted[7:0]};
         end
         ACC16: begin
            sel       = sb_sel_t'(4'b0011) << {addr[1], 1'b0};
            bus_wdata = {2{wdata[15:0]}};
            rdata     = {16'b0, shifted[15:0]};
         end
         ACC32: begin
            sel       = 4'b1111;
            bus_wdata = wdata;
            rdata     = bus_rdata;
         end
         default: begin                                // illegal sizes never reach the bus
            sel       = 4'b0000;
            bus_wdata = wdata;
            rdata     = bus_rdata;
         end
      endcase
   end

endmodule

// File: src/sb_master.sv
// system bus master
// checks size and alignment, runs one Wishbone classic cycle
// and reports completion, errors and read data

module sb_master
   import sb_bus_pkg::*;
(
   input  logic       clk,
   input  logic       dm_rst_n,
   input  logic       start_rd,
   input  logic       start_wr,
   input  sb_access_e sb_access,
   input  sb_addr_t   sb_addr,
   input  sb_data_t   sb_wdata,
   output sb_status_t sb_status,
   output wb_req_t    wb_req,
   input  wb_rsp_t    wb_rsp
);

   sb_state_e state, state_nxt;
   logic      is_write;                                // direction of the current access
   sb_err_e   err_code;
   sb_err_e   check_code;
   logic      unaligned, bad_size;
   sb_sel_t   lane_sel;
   sb_data_t  lane_wdata;
   sb_data_t  lane_rdata;
   sb_data_t  rdata_q;

   sb_lane_align lane_i (
      .access    (sb_access),
      .addr      (sb_addr),
      .wdata     (sb_wdata),
      .bus_rdata (wb_rsp.dat),
      .sel       (lane_sel),
      .bus_wdata (lane_wdata),
      .rdata     (lane_rdata)
   );

   // **************************************************
   // access checks
   // **************************************************
   assign bad_size   = (sb_access > ACC32);
   assign unaligned  = ((sb_access == ACC16) & sb_addr[0]) |
                       ((sb_access == ACC32) & (|sb_addr[1:0]));
   assign check_code = bad_size ? BAD_SIZE : (unaligned ? UNALIGNED : NONE);

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE:    if (start_rd || start_wr) state_nxt = CHECK;
         CHECK:   state_nxt = (check_code != NONE) ? DONE : BUS;
         BUS:     if (wb_rsp.ack || wb_rsp.err) state_nxt = DONE;
         DONE:    state_nxt = IDLE;
         default: state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!dm_rst_n) begin
         state    <= IDLE;
         is_write <= 1'b0;
         err_code <= NONE;
      end else begin
         state <= state_nxt;
         if (state == IDLE && (start_rd || start_wr)) begin
            is_write <= start_wr;
            err_code <= NONE;
         end else if (state == CHECK) begin
            err_code <= check_code;
         end else if (state == BUS && wb_rsp.err) begin
            err_code <= BUS_ERR;
         end
      end
   end

   // aligned read data, taken on ack
   always_ff @(posedge clk) begin
      if (state == BUS && wb_rsp.ack && !wb_rsp.err && !is_write) begin
         rdata_q <= lane_rdata;
      end
   end

   // **************************************************
   // outputs
   // **************************************************
   always_comb begin
      wb_req     = '0;
      wb_req.cyc = (state == BUS);
      wb_req.stb = (state == BUS);
      wb_req.we  = is_write;
      wb_req.adr = {sb_addr[31:2], 2'b00};
      wb_req.sel = lane_sel;
      wb_req.dat = lane_wdata;
   end

   always_comb begin
      sb_status             = '0;
      sb_status.busy        = (state != IDLE);
      sb_status.done        = (state == DONE);
      sb_status.err_valid   = (state == DONE) & (err_code != NONE);
      sb_status.err_code    = err_code;
      sb_status.rdata_valid = (state == DONE) & ~is_write & (err_code == NONE);
      sb_status.rdata       = rdata_q;
   end

endmodule

// File: testbench/dm_top_checker.sv
// Wishbone protocol checker for the debug module
// bound into dm_top, watches the system bus master port

module dm_top_checker
   import sb_bus_pkg::*;
(
   input logic    clk,
   input logic    rst_n,
   input logic    dmactive,
   input wb_req_t wb_req,
   input wb_rsp_t wb_rsp
);

   int unsigned fail_count = 0;                        // read by the testbench at the end

   stb_follows_cyc: assert property (@(posedge clk) disable iff (!rst_n)
      wb_req.stb == wb_req.cyc)
      else begin $error("stb differs from cyc"); fail_count++; end

   // request held until the slave answers
   req_stable: assert property (@(posedge clk) disable iff (!rst_n)
      (wb_req.cyc && !wb_rsp.ack && !wb_rsp.err) |=>
         (wb_req.cyc && $stable(wb_req.adr) && $stable(wb_req.we) &&
          $stable(wb_req.sel) && $stable(wb_req.dat)))
      else begin $error("request changed while waiting for the slave"); fail_count++; end

   cyc_drops: assert property (@(posedge clk) disable iff (!rst_n)
      (wb_req.cyc && (wb_rsp.ack || wb_rsp.err)) |=> !wb_req.cyc)
      else begin $error("cyc still high after ack or err"); fail_count++; end

   idle_inactive: assert property (@(posedge clk) disable iff (!rst_n)
      !dmactive |-> !wb_req.cyc)                       // debug logic held in reset
      else begin $error("cyc high while dmactive is 0"); fail_count++; end

endmodule

bind dm_top dm_top_checker checker_i (
   .clk      (clk),
   .rst_n    (rst_n),
   .dmactive (dmactive),
   .wb_req   (wb_req),
   .wb_rsp   (wb_rsp)
);

// File: testbench/dm_top_tb.sv
// debug module testbench
// table of DMI operations against dm_top, Wishbone slave memory model

module dm_top_tb
   import dm_reg_pkg::*;
   import sb_bus_pkg::*;
();

   typedef enum {OP_WR, OP_RD, OP_WAIT, OP_NDM, OP_MEM, OP_STALL,
                 OP_MARK, OP_QUIET, OP_BUS} op_e;

   // OP_BUS: addr is the bus adr, wdata the bus dat, exp[4] we and exp[3:0] sel
   typedef struct {
      op_e         op;
      logic [31:0] addr;
      dm_word_t    wdata;
      dm_word_t    exp;
   } step_t;

   logic     clk = 1'b0;
   logic     rst_n;
   dmi_req_t dmi_req;
   dm_word_t dmi_rdata;
   wb_req_t  wb_req;
   wb_rsp_t  wb_rsp;
   logic     ndm_reset;

   step_t    steps[$];
   int       limit_cycles = 0;
   integer   seed = 32'h5311_b483;
   sb_data_t mem [64];                                 // slave memory, word indexed
   logic     stall = 1'b0;
   logic     active = 1'b0;
   int       wait_left;
   int       cyc_cycles = 0;
   int       cyc_mark = 0;

   dm_top dm_top_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .dmi_req   (dmi_req),
      .dmi_rdata (dmi_rdata),
      .wb_req    (wb_req),
      .wb_rsp    (wb_rsp),
      .ndm_reset (ndm_reset)
   );

   always #10 clk = ~clk;

   // **************************************************
   // Wishbone slave model
   // **************************************************
   always @(posedge clk) begin
      #2;
      wb_rsp = '0;
      if (wb_req.cyc) cyc_cycles++;
      if (wb_req.cyc && wb_req.stb && !stall) begin
         if (!active) begin
            active = 1'b1;
            wait_left = $random(seed) & 32'h3;         // 0 to 3 wait cycles
         end
         if (wait_left != 0) begin
            wait_left--;
         end else begin
            active = 1'b0;
            if (wb_req.adr >= 32'h8000_0000) begin
               wb_rsp.err = 1'b1;
            end else begin
               wb_rsp.ack = 1'b1;
               for (int b = 0; b < 4; b++) begin
                  if (wb_req.we && wb_req.sel[b])
                     mem[wb_req.adr[7:2]][8*b +: 8] = wb_req.dat[8*b +: 8];
               end
               if (!wb_req.we) wb_rsp.dat = mem[wb_req.adr[7:2]];
            end
         end
      end
   end

   // **************************************************
   // checks
   // **************************************************
   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TESTBENCH FAILED");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_word(input dm_word_t got, input dm_word_t exp, input string name);
      if (got !== exp)
         abort_run($sformatf("ERROR t=%0t %s exp %h got %h", $time, name, exp, got));
   endtask

   task automatic check_flag(input logic got, input logic exp, input string name);
      if (got !== exp)
         abort_run($sformatf("ERROR t=%0t %s exp %b got %b", $time, name, exp, got));
   endtask

   task automatic check_bus(input wb_req_t got, input wb_req_t exp);
      if (got.cyc !== exp.cyc || got.stb !== exp.stb)
         abort_run($sformatf("ERROR t=%0t wb_req.cyc/stb exp %b%b got %b%b",
                             $time, exp.cyc, exp.stb, got.cyc, got.stb));
      else if (got.we !== exp.we)
         abort_run($sformatf("ERROR t=%0t wb_req.we exp %b got %b", $time, exp.we, got.we));
      else if (got.adr !== exp.adr)
         abort_run($sformatf("ERROR t=%0t wb_req.adr exp %h got %h", $time, exp.adr, got.adr));
      else if (got.sel !== exp.sel)
         abort_run($sformatf("ERROR t=%0t wb_req.sel exp %b got %b", $time, exp.sel, got.sel));
      else if (got.dat !== exp.dat)
         abort_run($sformatf("ERROR t=%0t wb_req.dat exp %h got %h", $time, exp.dat, got.dat));
   endtask

   function automatic string reg_name(input dmi_addr_t addr);
      case (addr)
         DMCONTROL_ADDR:  return "dmcontrol";
         SBCS_ADDR:       return "sbcs";
         SBADDRESS0_ADDR: return "sbaddress0";
         SBDATA0_ADDR:    return "sbdata0";
         default:         return "dmi_rdata";
      endcase
   endfunction

   // **************************************************
   // DMI driver and table
   // **************************************************
   // one access, returns 2 units after the edge that took it
   task automatic dmi_access(input logic wr, input dmi_addr_t addr, input dm_word_t wdata);
      dmi_req.en    = 1'b1;
      dmi_req.wr    = wr;
      dmi_req.addr  = addr;
      dmi_req.wdata = wdata;
      @(posedge clk);
      #2;
      dmi_req = '0;
   endtask

   task automatic wait_idle(input dm_word_t exp);
      int polls;
      polls = 0;
      dmi_access(1'b0, SBCS_ADDR, '0);
      while (dmi_rdata[SBCS_SBBUSY] === 1'b1) begin
         polls++;
         if (polls > 50) abort_run("sbbusy did not clear after 50 polls of sbcs");
         else dmi_access(1'b0, SBCS_ADDR, '0);
      end
      check_word(dmi_rdata, exp, "sbcs");
   endtask

   task automatic run_step(input step_t s);
      wb_req_t exp_req;
      int      tries;
      case (s.op)
         OP_WR: dmi_access(1'b1, dmi_addr_t'(s.addr), s.wdata);
         OP_RD: begin
            dmi_access(1'b0, dmi_addr_t'(s.addr), '0);
            check_word(dmi_rdata, s.exp, reg_name(dmi_addr_t'(s.addr)));
         end
         OP_WAIT:  wait_idle(s.exp);
         OP_NDM:   check_flag(ndm_reset, s.exp[0], "ndm_reset");
         OP_MEM:   check_word(mem[s.addr[7:2]], s.exp, $sformatf("mem[%h]", s.addr));
         OP_STALL: stall <= s.wdata[0];
         OP_MARK:  cyc_mark = cyc_cycles;
         OP_QUIET: begin
            if (cyc_cycles != cyc_mark)
               abort_run("a Wishbone cycle was started for a rejected access");
         end
         OP_BUS: begin
            tries = 0;
            while (wb_req.cyc !== 1'b1) begin          // start goes through CHECK first
               tries++;
               if (tries > 10) abort_run("no Wishbone cycle started for the pending access");
               else begin
                  @(posedge clk);
                  #2;
               end
            end
            exp_req     = '0;
            exp_req.cyc = 1'b1;
            exp_req.stb = 1'b1;
            exp_req.we  = s.exp[4];
            exp_req.adr = s.addr;
            exp_req.sel = s.exp[3:0];
            exp_req.dat = s.wdata;
            check_bus(wb_req, exp_req);
         end
         default: abort_run("unknown operation in the test table");
      endcase
   endtask

   function automatic void add_step(op_e op, logic [31:0] addr, dm_word_t wdata, dm_word_t exp);
      step_t s;
      s.op    = op;
      s.addr  = addr;
      s.wdata = wdata;
      s.exp   = exp;
      steps.push_back(s);
   endfunction

   function automatic void build_table();
      // activation and ndmreset
      add_step(OP_RD,    SBCS_ADDR,       0,             32'h0000_0000);
      add_step(OP_WR,    DMCONTROL_ADDR,  32'h1,         0);
      add_step(OP_RD,    SBCS_ADDR,       0,             32'h2000_0407);
      add_step(OP_WR,    DMCONTROL_ADDR,  32'h3,         0);
      add_step(OP_NDM,   0,               0,             32'h1);
      add_step(OP_RD,    DMCONTROL_ADDR,  0,             32'h3);
      add_step(OP_WR,    DMCONTROL_ADDR,  32'h1,         0);
      add_step(OP_NDM,   0,               0,             32'h0);
      // word write, then read back through read-on-address
      add_step(OP_WR,    SBCS_ADDR,       32'h0004_0000, 0);
      add_step(OP_WR,    SBADDRESS0_ADDR, 32'h10,        0);
      add_step(OP_WR,    SBDATA0_ADDR,    32'hcafe_f00d, 0);
      add_step(OP_WAIT,  0,               0,             32'h2004_0407);
      add_step(OP_MEM,   32'h10,          0,             32'hcafe_f00d);
      add_step(OP_WR,    SBADDRESS0_ADDR, 32'h14,        0);
      add_step(OP_WR,    SBDATA0_ADDR,    32'h1234_5678, 0);
      add_step(OP_WAIT,  0,               0,             32'h2004_0407);
      add_step(OP_WR,    SBCS_ADDR,       32'h0014_0000, 0);
      add_step(OP_WR,    SBADDRESS0_ADDR, 32'h10,        0);
      add_step(OP_WAIT,  0,               0,             32'h2014_0407);
      add_step(OP_RD,    SBDATA0_ADDR,    0,             32'hcafe_f00d);
      add_step(OP_RD,    SBADDRESS0_ADDR, 0,             32'h10);
      // lane steering, byte at offset 1 and halfword at offset 2
      add_step(OP_WR,    SBCS_ADDR,       32'h0004_0000, 0);
      add_step(OP_WR,    SBADDRESS0_ADDR, 32'h20,        0);
      add_step(OP_WR,    SBDATA0_ADDR,    32'h4433_2211, 0);
      add_step(OP_WAIT,  0,               0,             32'h2004_0407);
      add_step(OP_WR,    SBCS_ADDR,       32'h0000_0000, 0);
      add_step(OP_WR,    SBADDRESS0_ADDR, 32'h21,        0);
      add_step(OP_WR,    SBDATA0_ADDR,    32'hffff_ffab, 0);
      add_step(OP_WAIT,  0,               0,             32'h2000_0407);
      add_step(OP_MEM,   32'h20,          0,             32'h4433_ab11);
      add_step(OP_WR,    SBCS_ADDR,       32'h0002_0000, 0);
      add_step(OP_WR,    SBADDRESS0_ADDR, 32'h22,        0);
      add_step(OP_WR,    SBDATA0_ADDR,    32'h5555_beef, 0);
      add_step(OP_WAIT,  0,               0,             32'h2002_0407);
      add_step(OP_MEM,   32'h20,          0,             32'hbeef_ab11);
      add_step(OP_WR,    SBCS_ADDR,       32'h0010_0000, 0);
      add_step(OP_WR,    SBADDRESS0_ADDR, 32'h23,        0);
      add_step(OP_WAIT,  0,               0,             32'h2010_0407);
      add_step(OP_RD,    SBDATA0_ADDR,    0,             32'h0000_00be);
      add_step(OP_WR,    SBCS_ADDR,       32'h0012_0000, 0);
      add_step(OP_WR,    SBADDRESS0_ADDR, 32'h22,        0);
      add_step(OP_WAIT,  0,               0,             32'h2012_0407);
      add_step(OP_RD,    SBDATA0_ADDR,    0,             32'h0000_beef);
      // auto-increment with read-on-data
      add_step(OP_WR,    SBCS_ADDR,       32'h0015_8000, 0);
      add_step(OP_WR,    SBADDRESS0_ADDR, 32'h40,        0);
      add_step(OP_WAIT,  0,               0,             32'h2015_8407);
      add_step(OP_RD,    SBADDRESS0_ADDR, 0,             32'h44);
      add_step(OP_RD,    SBDATA0_ADDR,    0,             32'hd00d_0040);
      add_step(OP_WAIT,  0,               0,             32'h2015_8407);
      add_step(OP_RD,    SBDATA0_ADDR,    0,             32'hd00d_0044);
      add_step(OP_WAIT,  0,               0,             32'h2015_8407);
      add_step(OP_RD,    SBADDRESS0_ADDR, 0,             32'h4c);
      // unaligned, illegal size and bus error
      add_step(OP_WR,    SBCS_ADDR,       32'h0012_0000, 0);
      add_step(OP_MARK,  0,               0,             0);
      add_step(OP_WR,    SBADDRESS0_ADDR, 32'h41,        0);
      add_step(OP_WAIT,  0,               0,             32'h2012_3407);
      add_step(OP_QUIET, 0,               0,             0);
      add_step(OP_WR,    SBCS_ADDR,       32'h0012_7000, 0);
      add_step(OP_RD,    SBCS_ADDR,       0,             32'h2012_0407);
      add_step(OP_WR,    SBCS_ADDR,       32'h0016_0000, 0);
      add_step(OP_WR,    SBADDRESS0_ADDR, 32'h40,        0);
      add_step(OP_WAIT,  0,               0,             32'h2016_4407);
      add_step(OP_QUIET, 0,               0,             0);
      add_step(OP_WR,    SBCS_ADDR,       32'h0014_7000, 0);
      add_step(OP_RD,    SBCS_ADDR,       0,             32'h2014_0407);
      add_step(OP_WR,    SBADDRESS0_ADDR, 32'h8000_0010, 0);
      add_step(OP_WAIT,  0,               0,             32'h2014_2407);
      add_step(OP_WR,    SBCS_ADDR,       32'h0014_7000, 0);
      add_step(OP_RD,    SBCS_ADDR,       0,             32'h2014_0407);
      // busy collision against a stalled slave
      add_step(OP_WR,    SBCS_ADDR,       32'h0004_0000, 0);
      add_step(OP_WR,    SBADDRESS0_ADDR, 32'h30,        0);
      add_step(OP_STALL, 0,               32'h1,         0);
      add_step(OP_WR,    SBDATA0_ADDR,    32'h1357_9bdf, 0);
      add_step(OP_BUS,   32'h30,          32'h1357_9bdf, 32'h1f);
      add_step(OP_WR,    SBDATA0_ADDR,    32'h2468_ace0, 0);
      add_step(OP_BUS,   32'h30,          32'h1357_9bdf, 32'h1f);
      add_step(OP_RD,    SBCS_ADDR,       0,             32'h2064_0407);
      add_step(OP_STALL, 0,               32'h0,         0);
      add_step(OP_WAIT,  0,               0,             32'h2044_0407);
      add_step(OP_MEM,   32'h30,          0,             32'h1357_9bdf);
      add_step(OP_WR,    SBCS_ADDR,       32'h0044_0000, 0);
      add_step(OP_RD,    SBCS_ADDR,       0,             32'h2004_0407);
      add_step(OP_RD,    SBDATA0_ADDR,    0,             32'h1357_9bdf);
      // deactivate, debug registers read as zero again
      add_step(OP_WR,    DMCONTROL_ADDR,  32'h0,         0);
      add_step(OP_RD,    SBCS_ADDR,       0,             32'h0000_0000);
   endfunction

   // **************************************************
   // main sequence and watchdog
   // **************************************************
   initial begin
      rst_n   = 1'b0;
      dmi_req = '0;
      wb_rsp  = '0;
      for (int i = 0; i < 64; i++) begin
         mem[i] = 32'hd00d_0000 | sb_data_t'(i * 4);  // byte address in the low bits
      end
      build_table();
      limit_cycles = steps.size() * 40;
      repeat (3) @(posedge clk);
      #2;
      rst_n = 1'b1;
      for (int i = 0; i < steps.size(); i++) begin
         run_step(steps[i]);
      end
      @(posedge clk);
      #2;
      if (dm_top_i.checker_i.fail_count == 0) begin
         $display("TESTBENCH PASSED");
         $finish;
      end else begin
         abort_run("Wishbone protocol assertion failed during the run");
      end
   end

   initial begin
      wait (limit_cycles != 0);
      repeat (limit_cycles) @(posedge clk);
      abort_run($sformatf("timeout, test table not finished after %0d cycles", limit_cycles));
   end

endmodule
